// ==== src.f ====
rtl/cache_geom_pkg.sv
rtl/bridge_pkg.sv
rtl/cache_way.sv
rtl/cache_ctrl.sv
rtl/cache_top.sv
testbench/tb_bridge_mem.sv
testbench/tb_cache.sv

// ==== run.sh ====
#!/bin/sh
# build and run the cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_cache -Mdir obj_dir -o tb_cache
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_cache > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^No errors$" sim.log; then
	exit 0
fi
exit 1

// ==== testbench/tb_cache.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_cache
	import cache_geom_pkg::*;
	import bridge_pkg::*;
;

	localparam int num_reqs   = 2000;
	localparam int max_cycles = 60000;

	// one outstanding request as the model sees it
	typedef struct packed {
		cache_op_e   op;
		logic [31:0] addr;
		logic [31:0] data;
		logic        fast;
		logic [31:0] cyc;
	} pend_t;

	logic        clk;
	logic        resetn;
	logic        valid;
	cpu_req_t    req;
	logic        addr_ok;
	logic        data_ok;
	logic [31:0] rdata;
	logic        rd_req;
	rd_req_t     rd_addr;
	logic        rd_rdy;
	logic        ret_valid;
	logic        ret_last;
	logic [31:0] ret_data;
	logic        wr_req;
	wb_req_t     wb;
	logic        wr_rdy;

	pend_t       pending [$];
	logic [31:0] ref_mem [int unsigned];
	// line took a store since its last refill
	bit          line_stored [int unsigned];
	// shadow directory of lines known to be resident
	logic [1:0]  res_valid [256];
	logic [19:0] res_tag [256][2];
	logic [31:0] cyc = '0;
	int          errors = 0;
	int          sent = 0;
	int          made = 0;
	bit          wb_seen = 0;
	bit          last_store = 0;
	bit          reset_seen = 0;
	bit          done = 0;

	cache_top DUT (
		.clk       (clk),
		.resetn    (resetn),
		.valid     (valid),
		.req       (req),
		.addr_ok   (addr_ok),
		.data_ok   (data_ok),
		.rdata     (rdata),
		.rd_req    (rd_req),
		.rd_addr   (rd_addr),
		.rd_rdy    (rd_rdy),
		.ret_valid (ret_valid),
		.ret_last  (ret_last),
		.ret_data  (ret_data),
		.wr_req    (wr_req),
		.wb        (wb),
		.wr_rdy    (wr_rdy)
	);

	tb_bridge_mem bridge (
		.clk       (clk),
		.resetn    (resetn),
		.rd_req    (rd_req),
		.rd_addr   (rd_addr),
		.rd_rdy    (rd_rdy),
		.ret_valid (ret_valid),
		.ret_last  (ret_last),
		.ret_data  (ret_data),
		.wr_req    (wr_req),
		.wb        (wb),
		.wr_rdy    (wr_rdy)
	);

	always #4 clk = ~clk;

	// same fill pattern as the backing memory
	function automatic logic [31:0] fill_word(input logic [29:0] waddr);
		return (32'(waddr) * 32'h9e3779b1) ^ 32'h5bd1e995;
	endfunction

	function automatic logic [31:0] ref_read(input logic [29:0] waddr);
		if (ref_mem.exists(32'(waddr)))
		begin
			return ref_mem[32'(waddr)];
		end
		return fill_word(waddr);
	endfunction

	function automatic logic is_resident(input logic [31:0] addr);
		logic [7:0] idx;
		idx = addr[11:4];
		return (res_valid[idx][0] && res_tag[idx][0] == addr[31:12]) ||
			(res_valid[idx][1] && res_tag[idx][1] == addr[31:12]);
	endfunction

	// 4 tags and 4 sets keep evictions common
	function automatic cpu_req_t make_req();
		cpu_req_t r;
		r.op     = ($urandom % 2 == 1) ? op_store : op_load;
		r.index  = 8'h05 + 8'($urandom % 4) * 8'h3c;
		r.tag    = 20'h1a2b0 + 20'($urandom % 4) * 20'h10101;
		r.offset = {2'($urandom % 4), 2'b00};
		r.wstrb  = (r.op == op_store) ? 4'($urandom % 15 + 1) : 4'h0;
		r.wdata  = $urandom;
		return r;
	endfunction

	task automatic drop_line(input logic [31:0] addr);
		logic [7:0] idx;
		idx = addr[11:4];
		for (int s = 0; s < 2; s++)
		begin
			if (res_valid[idx][s] && res_tag[idx][s] == addr[31:12])
			begin
				res_valid[idx][s] = 1'b0;
			end
		end
	endtask

	task automatic check_writeback();
		logic [31:0] base;
		logic [31:0] exp;
		base = wb.addr;
		for (int i = 0; i < 4; i++)
		begin
			exp = ref_read(base[31:2] + 30'(i));
			assert (wb.data[i*32 +: 32] == exp)
			else
			begin
				errors++;
				$display("mismatch writeback %h word %0d: expected %h actual %h",
					base, i, exp, wb.data[i*32 +: 32]);
			end
		end
		assert (line_stored.exists(base) && line_stored[base])
		else
		begin
			errors++;
			$display("write-back of line %h which took no store since its refill", base);
		end
		line_stored[base] = 0;
		drop_line(base);
		wb_seen = 1;
	endtask

	task automatic note_refill();
		logic [31:0] base;
		logic [7:0]  idx;
		base = rd_addr.addr;
		idx  = base[11:4];
		assert (!is_resident(base))
		else
		begin
			errors++;
			$display("unexpected refill of resident line %h", base);
		end
		// clean eviction leaves the victim unknown
		if (!wb_seen)
		begin
			res_valid[idx] = 2'b00;
		end
		if (!res_valid[idx][0])
		begin
			res_valid[idx][0] = 1'b1;
			res_tag[idx][0]   = base[31:12];
		end
		else
		begin
			res_valid[idx][1] = 1'b1;
			res_tag[idx][1]   = base[31:12];
		end
		line_stored[base] = 0;
		wb_seen = 0;
	endtask

	task automatic accept_req(input cpu_req_t r);
		pend_t       p;
		logic [31:0] addr;
		logic [31:0] w;
		addr = {r.tag, r.index, r.offset};
		w    = ref_read(addr[31:2]);
		if (r.op == op_store)
		begin
			for (int k = 0; k < 4; k++)
			begin
				if (r.wstrb[k])
				begin
					w[k*8 +: 8] = r.wdata[k*8 +: 8];
				end
			end
			ref_mem[addr[31:2]] = w;
		end
		p.op   = r.op;
		p.addr = addr;
		p.data = w;
		p.fast = is_resident(addr);
		p.cyc  = cyc;
		pending.push_back(p);
	endtask

	task automatic retire();
		pend_t p;
		assert (pending.size() != 0)
		else
		begin
			errors++;
			$display("data_ok with no request outstanding");
		end
		if (pending.size() != 0)
		begin
			p = pending.pop_front();
			if (p.op == op_load)
			begin
				assert (rdata == p.data)
				else
				begin
					errors++;
					$display("mismatch load %h: expected %h actual %h", p.addr, p.data, rdata);
				end
			end
			// resident line answers two cycles after acceptance
			if (p.fast)
			begin
				assert (cyc == p.cyc + 2)
				else
				begin
					errors++;
					$display("mismatch hit latency %h: expected %0d actual %0d",
						p.addr, 2, cyc - p.cyc);
				end
			end
			if (p.op == op_store)
			begin
				line_stored[{p.addr[31:4], 4'h0}] = 1;
			end
		end
	endtask

	// cycle limit
	always @(posedge clk)
	begin
		cyc <= cyc + 1;
		if (cyc == max_cycles)
		begin
			$display("timeout after %0d cycles with %0d of %0d requests done, error count %0d",
				max_cycles, sent, num_reqs, errors);
			$display("Errors found");
			$finish;
		end
	end

	// monitor, model and request driver
	always @(posedge clk)
	begin
		if (resetn)
		begin
			if (!reset_seen)
			begin
				assert (addr_ok && !rd_req && !wr_req && !data_ok)
				else
				begin
					errors++;
					$display("outputs after reset are not idle");
				end
				reset_seen = 1;
			end
			if (rd_req)
			begin
				assert (rd_addr.addr[3:0] == 4'h0)
				else
				begin
					errors++;
					$display("mismatch rd_addr alignment: expected 0 actual %h", rd_addr.addr[3:0]);
				end
			end
			if (wr_req && wr_rdy)
			begin
				check_writeback();
			end
			if (rd_req && rd_rdy)
			begin
				note_refill();
			end
			if (data_ok)
			begin
				retire();
			end
			// store from last edge sits in lookup now
			if (last_store && valid && req.op == op_load)
			begin
				assert (!addr_ok)
				else
				begin
					errors++;
					$display("load accepted directly behind a store in lookup");
				end
			end
			last_store = valid && addr_ok && req.op == op_store;
			if (valid && addr_ok)
			begin
				accept_req(req);
				sent++;
			end
			if (!valid || addr_ok)
			begin
				if (made < num_reqs && ($urandom % 4) != 0)
				begin
					req   <= make_req();
					valid <= 1'b1;
					made++;
				end
				else
				begin
					valid <= 1'b0;
				end
			end
			if (sent == num_reqs && pending.size() == 0)
			begin
				done = 1;
			end
		end
	end

	initial
	begin
		void'($urandom(32'h3c0a7f5b));
		clk    = 1'b0;
		resetn = 1'b0;
		valid  = 1'b0;
		req    = '0;
		for (int i = 0; i < 256; i++)
		begin
			res_valid[i] = 2'b00;
		end
		repeat (4) @(posedge clk);
		resetn <= 1'b1;
		wait (done);
		repeat (4) @(posedge clk);
		$display("error count %0d after %0d requests", errors, sent);
		if (errors == 0)
		begin
			$display("No errors");
		end
		else
		begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/tb_bridge_mem.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_bridge_mem
	import bridge_pkg::*;
(
	input  logic        clk,
	input  logic        resetn,
	input  logic        rd_req,
	input  rd_req_t     rd_addr,
	output logic        rd_rdy,
	output logic        ret_valid,
	output logic        ret_last,
	output logic [31:0] ret_data,
	input  logic        wr_req,
	input  wb_req_t     wb,
	output logic        wr_rdy
);

	// word-addressed backing store, untouched words come from the fill pattern
	logic [31:0] mem [int unsigned];
	logic [29:0] line_base;
	logic [29:0] wa;
	int          rd_wait = -1;
	int          wr_wait = -1;
	int          beats_left = 0;

	// odd multiplier keeps every word address distinct
	function automatic logic [31:0] fill_word(input logic [29:0] waddr);
		return (32'(waddr) * 32'h9e3779b1) ^ 32'h5bd1e995;
	endfunction

	function automatic logic [31:0] read_word(input logic [29:0] waddr);
		if (mem.exists(32'(waddr)))
		begin
			return mem[32'(waddr)];
		end
		return fill_word(waddr);
	endfunction

	initial
	begin
		rd_rdy    = 1'b0;
		wr_rdy    = 1'b0;
		ret_valid = 1'b0;
		ret_last  = 1'b0;
		ret_data  = '0;
	end

	always @(posedge clk)
	begin
		if (!resetn)
		begin
			rd_rdy     <= 1'b0;
			wr_rdy     <= 1'b0;
			ret_valid  <= 1'b0;
			ret_last   <= 1'b0;
			rd_wait    = -1;
			wr_wait    = -1;
			beats_left = 0;
		end
		else
		begin
			// write-back: random delay, then one ready pulse
			if (wr_req && wr_rdy)
			begin
				for (int i = 0; i < 4; i++)
				begin
					wa = wb.addr[31:2] + 30'(i);
					mem[32'(wa)] = wb.data[i*32 +: 32];
				end
				wr_rdy  <= 1'b0;
				wr_wait = -1;
			end
			else if (wr_req)
			begin
				if (wr_wait < 0)
				begin
					wr_wait = $urandom % 4;
				end
				if (wr_wait == 0)
				begin
					wr_rdy <= 1'b1;
				end
				else
				begin
					wr_wait = wr_wait - 1;
				end
			end
			// refill beats in word order with random gaps
			ret_valid <= 1'b0;
			ret_last  <= 1'b0;
			if (beats_left > 0 && ($urandom % 3) != 0)
			begin
				ret_valid  <= 1'b1;
				ret_data   <= read_word(line_base + 30'(4 - beats_left));
				ret_last   <= (beats_left == 1);
				beats_left = beats_left - 1;
			end
			// read request handshake, beats start next cycle
			if (rd_req && rd_rdy)
			begin
				line_base  = rd_addr.addr[31:2];
				beats_left = 4;
				rd_rdy     <= 1'b0;
				rd_wait    = -1;
			end
			else if (rd_req && beats_left == 0)
			begin
				if (rd_wait < 0)
				begin
					rd_wait = $urandom % 4;
				end
				if (rd_wait == 0)
				begin
					rd_rdy <= 1'b1;
				end
				else
				begin
					rd_wait = rd_wait - 1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/cache_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_top
	import cache_geom_pkg::*;
	import bridge_pkg::*;
(
	input  logic              clk,
	input  logic              resetn,
	// processor side
	input  logic              valid,
	input  cpu_req_t          req,
	output logic              addr_ok,
	output logic              data_ok,
	output logic [word_w-1:0] rdata,
	// bridge read channel
	output logic              rd_req,
	output rd_req_t           rd_addr,
	input  logic              rd_rdy,
	input  logic              ret_valid,
	input  logic              ret_last,
	input  logic [word_w-1:0] ret_data,
	// bridge write-back channel
	output logic              wr_req,
	output wb_req_t           wb,
	input  logic              wr_rdy
);

	way_wr_t way0_wr;
	way_wr_t way1_wr;
	way_rd_t way0_rd;
	way_rd_t way1_rd;

	cache_ctrl ctrl (
		.clk       (clk),
		.resetn    (resetn),
		.valid     (valid),
		.req       (req),
		.addr_ok   (addr_ok),
		.data_ok   (data_ok),
		.rdata     (rdata),
		.way0_wr   (way0_wr),
		.way1_wr   (way1_wr),
		.way0_rd   (way0_rd),
		.way1_rd   (way1_rd),
		.rd_req    (rd_req),
		.rd_addr   (rd_addr),
		.rd_rdy    (rd_rdy),
		.ret_valid (ret_valid),
		.ret_last  (ret_last),
		.ret_data  (ret_data),
		.wr_req    (wr_req),
		.wb        (wb),
		.wr_rdy    (wr_rdy)
	);

	// two identical ways
	cache_way way0 (
		.clk    (clk),
		.resetn (resetn),
		.wr     (way0_wr),
		.rd     (way0_rd)
	);

	cache_way way1 (
		.clk    (clk),
		.resetn (resetn),
		.wr     (way1_wr),
		.rd     (way1_rd)
	);

endmodule

`default_nettype wire

// ==== rtl/cache_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_ctrl
	import cache_geom_pkg::*;
	import bridge_pkg::*;
(
	input  logic              clk,
	input  logic              resetn,
	input  logic              valid,
	input  cpu_req_t          req,
	output logic              addr_ok,
	output logic              data_ok,
	output logic [word_w-1:0] rdata,
	output way_wr_t           way0_wr,
	output way_wr_t           way1_wr,
	input  way_rd_t           way0_rd,
	input  way_rd_t           way1_rd,
	output logic              rd_req,
	output rd_req_t           rd_addr,
	input  logic              rd_rdy,
	input  logic              ret_valid,
	input  logic              ret_last,
	input  logic [word_w-1:0] ret_data,
	output logic              wr_req,
	output wb_req_t           wb,
	input  logic              wr_rdy
);

	cache_state_e      state;
	cache_state_e      state_next;
	cpu_req_t          req_buf;
	way_rd_t           rd_arr [2];
	way_wr_t           wr_cmd [2];
	logic [1:0]        hit_way;
	logic              hit;
	logic              lookup;
	logic              accept;
	logic              store_hit;
	logic              refill_beat;
	logic [1:0]        word_sel;
	logic [1:0]        beat_cnt;
	logic              victim;
	logic [22:0]       lfsr;
	way_rd_t           vic;
	logic              need_wb;
	logic [word_w-1:0] hit_word;
	logic [word_w-1:0] beat_word;
	logic [word_w-1:0] refill_word;

	// byte merge of store data into a word
	function automatic logic [word_w-1:0] merge_word(input logic [word_w-1:0] old_w,
		input logic [word_w-1:0] new_w, input logic [3:0] strb);
		logic [word_w-1:0] res;
		res = old_w;
		for (int k = 0; k < word_w / 8; k++)
		begin
			if (strb[k])
			begin
				res[k*8 +: 8] = new_w[k*8 +: 8];
			end
		end
		return res;
	endfunction

	assign rd_arr[0] = way0_rd;
	assign rd_arr[1] = way1_rd;
	assign way0_wr   = wr_cmd[0];
	assign way1_wr   = wr_cmd[1];

	// tag compare on the buffered request
	assign hit_way[0] = rd_arr[0].valid && (rd_arr[0].tag == req_buf.tag);
	assign hit_way[1] = rd_arr[1].valid && (rd_arr[1].tag == req_buf.tag);
	assign hit        = |hit_way;
	assign lookup     = (state == st_lookup);
	assign word_sel   = req_buf.offset[offset_w-1:2];
	assign hit_word   = hit_way[1] ? rd_arr[1].line[word_sel*word_w +: word_w] :
		rd_arr[0].line[word_sel*word_w +: word_w];

	// load behind a store waits a cycle
	assign addr_ok = (state == st_idle) || (lookup && hit &&
		!(req_buf.op == op_store && req.op == op_load));
	assign accept      = valid && addr_ok;
	assign store_hit   = lookup && hit && (req_buf.op == op_store);
	assign refill_beat = (state == st_refill) && ret_valid;

	// victim selected at lookup, stable from st_miss on
	assign vic     = victim ? rd_arr[1] : rd_arr[0];
	assign need_wb = vic.valid && vic.dirty;

	// refill beat, merged if it carries the missing store
	assign beat_word = (req_buf.op == op_store && beat_cnt == word_sel) ?
		merge_word(ret_data, req_buf.wdata, req_buf.wstrb) : ret_data;

	// line-aligned bridge addresses
	assign rd_addr.addr = {req_buf.tag, req_buf.index, {offset_w{1'b0}}};
	assign wb.addr      = {vic.tag, req_buf.index, {offset_w{1'b0}}};
	assign wb.data      = vic.line;

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			req_buf <= req;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			state <= st_idle;
		end
		else
		begin
			state <= state_next;
		end
	end

	always_comb
	begin
		state_next = state;
		case (state)
			st_idle:
			begin
				if (accept)
				begin
					state_next = st_lookup;
				end
			end
			st_lookup:
			begin
				if (!hit)
				begin
					state_next = st_miss;
				end
				else if (!accept)
				begin
					state_next = st_idle;
				end
			end
			st_miss:
			begin
				// clean or empty victim skips write-back
				if (!need_wb || (wr_req && wr_rdy))
				begin
					state_next = st_replace;
				end
			end
			st_replace:
			begin
				if (rd_req && rd_rdy)
				begin
					state_next = st_refill;
				end
			end
			st_refill:
			begin
				if (ret_valid && ret_last)
				begin
					state_next = st_idle;
				end
			end
			default:
			begin
				state_next = st_idle;
			end
		endcase
	end

	// lfsr free runs, victim latched on lookup miss
	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			lfsr     <= lfsr_seed;
			victim   <= 1'b0;
			beat_cnt <= '0;
		end
		else
		begin
			lfsr <= {lfsr[21:0], lfsr[22] ^ lfsr[17]};
			if (lookup && !hit)
			begin
				victim <= lfsr[0];
			end
			// wraps back to zero after the fourth beat
			if (refill_beat)
			begin
				beat_cnt <= beat_cnt + 2'd1;
			end
		end
	end

	// bridge request strobes
	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			wr_req <= 1'b0;
			rd_req <= 1'b0;
		end
		else
		begin
			if (wr_req && wr_rdy)
			begin
				wr_req <= 1'b0;
			end
			else if (state == st_miss && need_wb)
			begin
				wr_req <= 1'b1;
			end
			if (rd_req && rd_rdy)
			begin
				rd_req <= 1'b0;
			end
			else if (state == st_replace)
			begin
				rd_req <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			data_ok <= 1'b0;
		end
		else
		begin
			data_ok <= (lookup && hit) || (refill_beat && ret_last);
		end
	end

	// rdata only moves together with data_ok
	always_ff @(posedge clk)
	begin
		if (refill_beat && beat_cnt == word_sel)
		begin
			refill_word <= beat_word;
		end
		if (lookup && hit)
		begin
			rdata <= hit_word;
		end
		else if (refill_beat && ret_last)
		begin
			rdata <= (beat_cnt == word_sel) ? beat_word : refill_word;
		end
	end

	// per-way write and read commands
	always_comb
	begin
		for (int w = 0; w < 2; w++)
		begin
			wr_cmd[w]          = '0;
			wr_cmd[w].index    = req_buf.index;
			wr_cmd[w].tag      = req_buf.tag;
			wr_cmd[w].valid    = 1'b1;
			wr_cmd[w].dirty    = (req_buf.op == op_store);
			// new request on accept, victim re-read on miss
			wr_cmd[w].rd_index = accept ? req.index : req_buf.index;
			wr_cmd[w].rd_en    = accept || (lookup && !hit);
			for (int b = 0; b < num_banks; b++)
			begin
				wr_cmd[w].wdata[b] = store_hit ? req_buf.wdata : beat_word;
			end
			if (store_hit && hit_way[w])
			begin
				wr_cmd[w].ben[word_sel] = req_buf.wstrb;
				wr_cmd[w].dirty_we      = 1'b1;
			end
			if (refill_beat && victim == 1'(w))
			begin
				wr_cmd[w].ben[beat_cnt] = 4'hf;
				// tag, valid and dirty land with the last beat
				wr_cmd[w].tag_we   = ret_last;
				wr_cmd[w].dirty_we = ret_last;
			end
		end
	end

	one_way_hits: assert property (@(posedge clk) disable iff (!resetn)
		lookup |-> !(hit_way[0] && hit_way[1]));

	bridge_one_channel: assert property (@(posedge clk) disable iff (!resetn)
		!(rd_req && wr_req));

endmodule

`default_nettype wire

// ==== rtl/cache_way.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_way
	import cache_geom_pkg::*;
(
	input  logic    clk,
	input  logic    resetn,
	input  way_wr_t wr,
	output way_rd_t rd
);

	logic [tag_w-1:0]    tag_mem [num_sets];
	logic [word_w-1:0]   bank_mem [num_banks][num_sets];
	logic [num_sets-1:0] valid_bits;
	logic [num_sets-1:0] dirty_bits;
	logic                same_set;
	way_rd_t             rd_next;

	// read and write hit the same set
	assign same_set = (wr.rd_index == wr.index);

	// tag array and byte-strobed data banks
	always_ff @(posedge clk)
	begin
		if (wr.tag_we)
		begin
			tag_mem[wr.index] <= wr.tag;
		end
		for (int b = 0; b < num_banks; b++)
		begin
			for (int k = 0; k < word_w / 8; k++)
			begin
				if (wr.ben[b][k])
				begin
					bank_mem[b][wr.index][k*8 +: 8] <= wr.wdata[b][k*8 +: 8];
				end
			end
		end
	end

	// valid goes in with the tag
	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			valid_bits <= '0;
			dirty_bits <= '0;
		end
		else
		begin
			if (wr.tag_we)
			begin
				valid_bits[wr.index] <= wr.valid;
			end
			if (wr.dirty_we)
			begin
				dirty_bits[wr.index] <= wr.dirty;
			end
		end
	end

	// write-first view of the addressed set
	// back-to-back stores to one set see fresh dirty and data
	always_comb
	begin
		rd_next.tag   = (same_set && wr.tag_we) ? wr.tag : tag_mem[wr.rd_index];
		rd_next.valid = (same_set && wr.tag_we) ? wr.valid : valid_bits[wr.rd_index];
		rd_next.dirty = (same_set && wr.dirty_we) ? wr.dirty : dirty_bits[wr.rd_index];
		for (int b = 0; b < num_banks; b++)
		begin
			for (int k = 0; k < word_w / 8; k++)
			begin
				rd_next.line[b*word_w + k*8 +: 8] = (same_set && wr.ben[b][k]) ?
					wr.wdata[b][k*8 +: 8] : bank_mem[b][wr.rd_index][k*8 +: 8];
			end
		end
	end

	// synchronous read held while rd_en is low
	always_ff @(posedge clk)
	begin
		if (wr.rd_en)
		begin
			rd <= rd_next;
		end
	end

	// tag install comes with a valid bit and the last bank of the line
	tag_installs_valid: assert property (@(posedge clk) disable iff (!resetn)
		wr.tag_we |-> (wr.valid && wr.ben[num_banks-1] == 4'hf));

endmodule

`default_nettype wire

// ==== rtl/bridge_pkg.sv ====
`default_nettype none

package bridge_pkg;

	// bridge side address
	localparam int addr_w = 32;

	// one refill beat is one word
	localparam int beat_w = 32;

	// beats per cache line
	localparam int line_beats = 4;

	// line read request, low offset bits always zero
	typedef struct packed {
		logic [addr_w-1:0] addr;
	} rd_req_t;

	// whole-line write-back
	typedef struct packed {
		logic [addr_w-1:0]            addr;
		logic [line_beats*beat_w-1:0] data;
	} wb_req_t;

endpackage

`default_nettype wire

// ==== rtl/cache_geom_pkg.sv ====
`default_nettype none

package cache_geom_pkg;

	// address split is tag | index | offset
	localparam int tag_w     = 20;
	localparam int index_w   = 8;
	localparam int offset_w  = 4;
	localparam int num_sets  = 256;
	localparam int num_banks = 4;
	localparam int word_w    = 32;
	localparam int line_w    = 128;

	// victim LFSR start value
	localparam logic [22:0] lfsr_seed = 23'h2a00ff;

	typedef enum logic {op_load = 1'b0, op_store = 1'b1} cache_op_e;

	typedef enum logic [2:0] {
		st_idle    = 3'd0,
		st_lookup  = 3'd1,
		st_miss    = 3'd2,
		st_replace = 3'd3,
		st_refill  = 3'd4
	} cache_state_e;

	// processor request, also held in the request buffer
	typedef struct packed {
		cache_op_e                 op;
		logic [index_w-1:0]        index;
		logic [tag_w-1:0]          tag;
		logic [offset_w-1:0]       offset;
		logic [3:0]                wstrb;
		logic [word_w-1:0]         wdata;
	} cpu_req_t;

	// write command to one way, plus its read port
	typedef struct packed {
		logic [index_w-1:0]                  index;
		logic                                tag_we;
		logic [tag_w-1:0]                    tag;
		logic                                valid;
		logic                                dirty_we;
		logic                                dirty;
		logic [num_banks-1:0][3:0]           ben;
		logic [num_banks-1:0][word_w-1:0]    wdata;
		logic [index_w-1:0]                  rd_index;
		logic                                rd_en;
		logic [16:0]                         spare;
	} way_wr_t;

	typedef struct packed {
		logic [tag_w-1:0]  tag;
		logic              valid;
		logic              dirty;
		logic [line_w-1:0] line;
	} way_rd_t;

endpackage

`default_nettype wire
